// File: src/snakePkg.sv
// snake game package with screen, block, colour and credit constants and shared structs
package snakePkg;

    // coordinate widths
    localparam int xWidth = 8;
    localparam int yWidth = 7;
    localparam int colorWidth = 3;

    // visible screen in pixels
    localparam int screenWidth = 160;
    localparam int screenHeight = 120;

    // square block edge
    localparam int blockSize = 10;

    // segment store depth and its count width
    localparam int maxLength = 4;
    localparam int lengthWidth = 3;

    // head origin after reset, body hangs below it
    localparam int startX = 80;
    localparam int startY = 60;

    // apple is fixed
    localparam int appleX = 30;
    localparam int appleY = 30;
    localparam logic [colorWidth-1:0] appleColor = 3'b100;

    // background
    localparam logic [colorWidth-1:0] eraseColor = '0;

    // credits held by the raster after reset
    localparam int creditDepth = 4;

    // step divider, one tick every 64 cycles
    localparam int tickBits = 6;

    // screen coordinate
    typedef struct packed {
        logic [xWidth-1:0] x;
        logic [yWidth-1:0] y;
    } point;

    // one pixel towards the frame writer
    typedef struct packed {
        point pos;
        logic [colorWidth-1:0] color;
    } pixelWrite;

    // direction keys, active high
    typedef struct packed {
        logic right;
        logic down;
        logic up;
        logic left;
    } keyPad;

    // block to be scanned by the raster
    typedef struct packed {
        point origin;
        logic [colorWidth-1:0] color;
    } blockRequest;

endpackage

// File: src/collisionCheck.sv
// collision test of the head against screen borders and active body segments
`timescale 1ns/100ps

module collisionCheck
(
    input  snakePkg::point [snakePkg::maxLength-1:0] segments,
    input  logic [snakePkg::lengthWidth-1:0] length,
    output logic hit
);

    logic borderHit;
    logic bodyHit;
    logic [snakePkg::xWidth-1:0] dx;
    logic [snakePkg::yWidth-1:0] dy;

    // head sitting on any of the four borders
    assign borderHit = (segments[0].x == '0)
        || (segments[0].x == snakePkg::xWidth'(snakePkg::screenWidth - snakePkg::blockSize))
        || (segments[0].y == '0)
        || (segments[0].y == snakePkg::yWidth'(snakePkg::screenHeight - snakePkg::blockSize));

    // overlap with any active segment behind the head
    always_comb
    begin
        bodyHit = 1'b0;
        dx = '0;
        dy = '0;
        for (int i = 1; i < snakePkg::maxLength; i++)
        begin
            // absolute distances on each axis
            dx = (segments[0].x > segments[i].x) ? segments[0].x - segments[i].x
                                                  : segments[i].x - segments[0].x;
            dy = (segments[0].y > segments[i].y) ? segments[0].y - segments[i].y
                                                  : segments[i].y - segments[0].y;
            // only segments inside the current length count
            if ((snakePkg::lengthWidth'(i) < length)
                && (dx < snakePkg::xWidth'(snakePkg::blockSize))
                && (dy < snakePkg::yWidth'(snakePkg::blockSize)))
            begin
                bodyHit = 1'b1;
            end
        end
    end

    assign hit = borderHit || bodyHit;

endmodule

// File: src/snakeBody.sv
// snake body store with heading latch, block stepping of the head and segment shift
`timescale 1ns/100ps

module snakeBody
(
    input  logic Clock,
    input  logic reset,
    input  snakePkg::keyPad keys,
    input  logic grow,
    input  logic moveStep,
    output snakePkg::point [snakePkg::maxLength-1:0] segments,
    output logic [snakePkg::lengthWidth-1:0] length
);

    // one-hot heading, all zero until the first key
    snakePkg::keyPad heading;

    // next head position from the current heading
    snakePkg::point nextHead;

    // any heading latched yet
    logic headingValid;

    assign headingValid = |heading;

    // heading latch, priority right then down, up, left
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            heading <= '0;
        end
        else if (keys.right)
        begin
            heading <= 4'b1000;
        end
        else if (keys.down)
        begin
            heading <= 4'b0100;
        end
        else if (keys.up)
        begin
            heading <= 4'b0010;
        end
        else if (keys.left)
        begin
            heading <= 4'b0001;
        end
        // no key keeps the last heading
    end

    // head moves one whole block per step
    always_comb
    begin
        nextHead = segments[0];
        if (heading.right)
        begin
            nextHead.x = segments[0].x + snakePkg::xWidth'(snakePkg::blockSize);
        end
        else if (heading.down)
        begin
            nextHead.y = segments[0].y + snakePkg::yWidth'(snakePkg::blockSize);
        end
        else if (heading.up)
        begin
            nextHead.y = segments[0].y - snakePkg::yWidth'(snakePkg::blockSize);
        end
        else if (heading.left)
        begin
            nextHead.x = segments[0].x - snakePkg::xWidth'(snakePkg::blockSize);
        end
    end

    // segment shift store
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // vertical body below the head, one block apart
            for (int i = 0; i < snakePkg::maxLength; i++)
            begin
                segments[i].x <= snakePkg::xWidth'(snakePkg::startX);
                segments[i].y <= snakePkg::yWidth'(snakePkg::startY + i * snakePkg::blockSize);
            end
        end
        else if (moveStep && headingValid)
        begin
            // each segment follows its neighbour towards the head
            for (int i = snakePkg::maxLength - 1; i > 0; i--)
            begin
                segments[i] <= segments[i-1];
            end
            segments[0] <= nextHead;
        end
    end

    // length count, saturates at the store depth
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            length <= snakePkg::lengthWidth'(1);
        end
        else if (grow && (length < snakePkg::lengthWidth'(snakePkg::maxLength)))
        begin
            length <= length + 1'b1;
        end
    end

endmodule

// File: src/blockRaster.sv
// block raster scanning one 10x10 block into a credit-controlled pixel stream
`timescale 1ns/100ps

module blockRaster
(
    input  logic Clock,
    input  logic reset,
    input  logic blockStart,
    input  snakePkg::blockRequest request,
    input  logic pixelCredit,
    output logic blockDone,
    output snakePkg::pixelWrite pixel,
    output logic pixelValid
);

    // captured request for the block in flight
    snakePkg::blockRequest current;

    // scan offsets, x runs fastest
    logic [$clog2(snakePkg::blockSize)-1:0] xOffset;
    logic [$clog2(snakePkg::blockSize)-1:0] yOffset;

    // offsets widened to coordinate size
    logic [snakePkg::xWidth-1:0] xStep;
    logic [snakePkg::yWidth-1:0] yStep;

    // scan in progress
    logic busy;

    // free credits, zero means the frame writer is full
    logic [$clog2(snakePkg::creditDepth + 1)-1:0] credits;

    logic lastPixel;

    assign xStep = snakePkg::xWidth'(xOffset);
    assign yStep = snakePkg::yWidth'(yOffset);

    // a pixel leaves only while a credit is held
    assign pixelValid = busy && (credits != '0);

    assign pixel.pos.x = current.origin.x + xStep;
    assign pixel.pos.y = current.origin.y + yStep;
    assign pixel.color = current.color;

    assign lastPixel = (xOffset == ($bits(xOffset))'(snakePkg::blockSize - 1))
        && (yOffset == ($bits(yOffset))'(snakePkg::blockSize - 1));

    // request payload, loaded on start only
    always_ff @(posedge Clock)
    begin
        if (blockStart)
        begin
            current <= request;
        end
    end

    // scan position, held while no credit is available
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            blockDone <= 1'b0;
            xOffset <= '0;
            yOffset <= '0;
        end
        else
        begin
            blockDone <= 1'b0;
            if (blockStart)
            begin
                busy <= 1'b1;
                xOffset <= '0;
                yOffset <= '0;
            end
            else if (pixelValid)
            begin
                if (lastPixel)
                begin
                    // done pulse follows the 100th pixel
                    busy <= 1'b0;
                    blockDone <= 1'b1;
                end
                else if (xOffset == ($bits(xOffset))'(snakePkg::blockSize - 1))
                begin
                    xOffset <= '0;
                    yOffset <= yOffset + 1'b1;
                end
                else
                begin
                    xOffset <= xOffset + 1'b1;
                end
            end
        end
    end

    // credit count, spend on a pixel and refill on a returned credit
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            credits <= ($bits(credits))'(snakePkg::creditDepth);
        end
        else if (pixelValid && !pixelCredit)
        begin
            credits <= credits - 1'b1;
        end
        else if (!pixelValid && pixelCredit)
        begin
            credits <= credits + 1'b1;
        end
    end

endmodule

// File: src/gameSequencer.sv
// game sequencer with step tick divider and draw, erase, check and move FSM
`timescale 1ns/100ps

module gameSequencer
(
    input  logic Clock,
    input  logic reset,
    input  logic start,
    input  logic hit,
    input  logic [snakePkg::colorWidth-1:0] snakeColor,
    input  snakePkg::point [snakePkg::maxLength-1:0] segments,
    input  logic [snakePkg::lengthWidth-1:0] length,
    input  logic blockDone,
    output logic blockStart,
    output snakePkg::blockRequest request,
    output logic moveStep,
    output logic gameOver
);

    typedef enum logic [3:0]
    {
        idle,
        startWait,
        appleDraw,
        snakeDraw,
        tickWait,
        eraseDraw,
        check,
        move,
        over
    } seqState;

    seqState state;

    // free running divider
    logic [snakePkg::tickBits-1:0] tickCount;
    logic tick;

    // segment being drawn or erased, counts down to the head
    logic [snakePkg::lengthWidth-1:0] segIndex;

    // length frozen for the whole frame so erase matches draw
    logic [snakePkg::lengthWidth-1:0] frameLength;

    assign tick = (tickCount == '0);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            tickCount <= '0;
        end
        else
        begin
            tickCount <= tickCount + 1'b1;
        end
    end

    // request payload, only read by the raster on blockStart
    always_ff @(posedge Clock)
    begin
        if ((state == startWait && tick) || state == move)
        begin
            // apple block at its fixed origin
            request.origin.x <= snakePkg::xWidth'(snakePkg::appleX);
            request.origin.y <= snakePkg::yWidth'(snakePkg::appleY);
            request.color <= snakePkg::appleColor;
        end
        else if (state == appleDraw && blockDone)
        begin
            request.origin <= segments[frameLength - 1'b1];
            request.color <= snakeColor;
        end
        else if (state == snakeDraw && blockDone && segIndex != '0)
        begin
            request.origin <= segments[segIndex - 1'b1];
            request.color <= snakeColor;
        end
        else if (state == tickWait && tick)
        begin
            request.origin <= segments[frameLength - 1'b1];
            request.color <= snakePkg::eraseColor;
        end
        else if (state == eraseDraw && blockDone && segIndex != '0)
        begin
            request.origin <= segments[segIndex - 1'b1];
            request.color <= snakePkg::eraseColor;
        end
    end

    // main FSM
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= idle;
            blockStart <= 1'b0;
            moveStep <= 1'b0;
            gameOver <= 1'b0;
            segIndex <= '0;
            frameLength <= '0;
        end
        else
        begin
            // single cycle pulses by default
            blockStart <= 1'b0;
            moveStep <= 1'b0;
            case (state)
                idle:
                begin
                    if (start)
                    begin
                        state <= startWait;
                    end
                end
                startWait:
                begin
                    // first frame starts on a tick
                    if (tick)
                    begin
                        frameLength <= length;
                        blockStart <= 1'b1;
                        state <= appleDraw;
                    end
                end
                appleDraw:
                begin
                    // tail first
                    if (blockDone)
                    begin
                        segIndex <= frameLength - 1'b1;
                        blockStart <= 1'b1;
                        state <= snakeDraw;
                    end
                end
                snakeDraw:
                begin
                    if (blockDone)
                    begin
                        if (segIndex == '0)
                        begin
                            state <= tickWait;
                        end
                        else
                        begin
                            segIndex <= segIndex - 1'b1;
                            blockStart <= 1'b1;
                        end
                    end
                end
                tickWait:
                begin
                    // snake stays on screen until the next tick
                    if (tick)
                    begin
                        segIndex <= frameLength - 1'b1;
                        blockStart <= 1'b1;
                        state <= eraseDraw;
                    end
                end
                eraseDraw:
                begin
                    if (blockDone)
                    begin
                        if (segIndex == '0)
                        begin
                            state <= check;
                        end
                        else
                        begin
                            segIndex <= segIndex - 1'b1;
                            blockStart <= 1'b1;
                        end
                    end
                end
                check:
                begin
                    if (hit)
                    begin
                        gameOver <= 1'b1;
                        state <= over;
                    end
                    else
                    begin
                        moveStep <= 1'b1;
                        state <= move;
                    end
                end
                move:
                begin
                    // body updates this cycle, next frame begins with the apple
                    frameLength <= length;
                    blockStart <= 1'b1;
                    state <= appleDraw;
                end
                over:
                begin
                    // held until reset
                    state <= over;
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// File: src/snakeGame.sv
// snake game top level joining sequencer, body store, collision test and block raster
`timescale 1ns/100ps

module snakeGame
(
    input  logic Clock,
    input  logic reset,
    input  snakePkg::keyPad keys,
    input  logic grow,
    input  logic start,
    input  logic [snakePkg::colorWidth-1:0] snakeColor,
    input  logic pixelCredit,
    output snakePkg::pixelWrite pixel,
    output logic pixelValid,
    output logic gameOver
);

    // body state, head at index 0
    snakePkg::point [snakePkg::maxLength-1:0] segments;
    logic [snakePkg::lengthWidth-1:0] length;

    // sequencer to raster
    snakePkg::blockRequest request;
    logic blockStart;
    logic blockDone;

    // sequencer to body and back from collision test
    logic moveStep;
    logic hit;

    gameSequencer sequencer
    (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .hit(hit),
        .snakeColor(snakeColor),
        .segments(segments),
        .length(length),
        .blockDone(blockDone),
        .blockStart(blockStart),
        .request(request),
        .moveStep(moveStep),
        .gameOver(gameOver)
    );

    snakeBody body
    (
        .Clock(Clock),
        .reset(reset),
        .keys(keys),
        .grow(grow),
        .moveStep(moveStep),
        .segments(segments),
        .length(length)
    );

    // pure combinational, sampled in the check state
    collisionCheck collision
    (
        .segments(segments),
        .length(length),
        .hit(hit)
    );

    blockRaster raster
    (
        .Clock(Clock),
        .reset(reset),
        .blockStart(blockStart),
        .request(request),
        .pixelCredit(pixelCredit),
        .blockDone(blockDone),
        .pixel(pixel),
        .pixelValid(pixelValid)
    );

endmodule

// File: dv/snakeGameChecker.sv
// assertion checker on the snake game pixel stream, credit use and game-over flag
`timescale 1ns/100ps

module snakeGameChecker
(
    input logic Clock,
    input logic reset,
    input snakePkg::pixelWrite pixel,
    input logic pixelValid,
    input logic pixelCredit,
    input logic gameOver
);

    // pixels sent and not yet paid back by a credit
    logic [3:0] inUse;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            inUse <= '0;
        end
        else
        begin
            inUse <= inUse + {3'b000, pixelValid} - {3'b000, pixelCredit};
        end
    end

    // stream is quiet once reset has been seen
    quietInReset: assert property (@(posedge Clock) reset |=> !pixelValid)
        else $error("pixelValid high right after a reset cycle");

    // frame writer never holds more than the credit depth
    creditBound: assert property (@(posedge Clock) disable iff (reset)
        int'(inUse) <= snakePkg::creditDepth)
        else $error("more pixels outstanding than credits exist");

    // every pixel lands on the visible screen
    pixelOnScreen: assert property (@(posedge Clock) disable iff (reset)
        pixelValid |-> (int'(pixel.pos.x) < snakePkg::screenWidth)
            && (int'(pixel.pos.y) < snakePkg::screenHeight))
        else $error("pixel written outside the screen");

    // game over is sticky until reset
    overHeld: assert property (@(posedge Clock) (gameOver && !reset) |=> gameOver)
        else $error("gameOver fell without a reset");

endmodule

bind snakeGame snakeGameChecker streamChecks
(
    .Clock(Clock),
    .reset(reset),
    .pixel(pixel),
    .pixelValid(pixelValid),
    .pixelCredit(pixelCredit),
    .gameOver(gameOver)
);

// File: dv/snakeGameTb.sv
// testbench for the snake game engine with a credit-returning frame writer model
`timescale 1ns/100ps

module snakeGameTb;

    logic Clock;
    logic reset;
    snakePkg::keyPad keys;
    logic grow;
    logic start;
    logic [snakePkg::colorWidth-1:0] snakeColor;
    logic pixelCredit;
    snakePkg::pixelWrite pixel;
    logic pixelValid;
    logic gameOver;

    // pixels seen on the stream, oldest first
    snakePkg::pixelWrite captured[$];
    // cycle at which each held credit goes back
    int creditDue[$];
    int cycleCount;
    int outstanding;
    int maxOutstanding;
    // long credit stalls when set
    logic slowCredits;
    logic [31:0] lfsrState;

    int errorCount;
    int timeoutCount;
    logic timedOut;
    int waitLimit = 20000;

    // expected body, index 0 is the head
    int modelX[snakePkg::maxLength];
    int modelY[snakePkg::maxLength];
    int modelLength;

    snakeGame uut
    (
        .Clock(Clock),
        .reset(reset),
        .keys(keys),
        .grow(grow),
        .start(start),
        .snakeColor(snakeColor),
        .pixelCredit(pixelCredit),
        .pixel(pixel),
        .pixelValid(pixelValid),
        .gameOver(gameOver)
    );

    always #2 Clock = ~Clock;

    // galois step, shift right and fold the tap mask on a one
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    // one step per bit taken
    function automatic int takeBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    // frame writer model, captures pixels and pays back credits one per cycle
    initial
    begin
        pixelCredit = 1'b0;
        forever
        begin
            @(posedge Clock);
            cycleCount++;
            if (reset)
            begin
                pixelCredit <= 1'b0;
                creditDue.delete();
                captured.delete();
                outstanding = 0;
            end
            else
            begin
                // credit driven last cycle reached the DUT at this edge
                if (pixelCredit)
                begin
                    outstanding--;
                end
                if (pixelValid)
                begin
                    captured.push_back(pixel);
                    outstanding++;
                    if (slowCredits)
                    begin
                        creditDue.push_back(cycleCount + takeBits(6) + 1);
                    end
                    else
                    begin
                        creditDue.push_back(cycleCount + takeBits(2) + 1);
                    end
                end
                if (outstanding > maxOutstanding)
                begin
                    maxOutstanding = outstanding;
                end
                if (creditDue.size() > 0 && creditDue[0] <= cycleCount)
                begin
                    void'(creditDue.pop_front());
                    pixelCredit <= 1'b1;
                end
                else
                begin
                    pixelCredit <= 1'b0;
                end
            end
        end
    end

    task automatic comparePixel(input string name, input snakePkg::pixelWrite got,
                                input snakePkg::pixelWrite exp);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got (%0d,%0d) color %0d expected (%0d,%0d) color %0d",
                $time, name, got.pos.x, got.pos.y, got.color,
                exp.pos.x, exp.pos.y, exp.color);
            errorCount++;
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // next captured pixel, gives up after waitLimit cycles
    task automatic waitPixel(output snakePkg::pixelWrite got);
        int waited;
        waited = 0;
        got = '0;
        while (captured.size() == 0 && !timedOut && waited < waitLimit)
        begin
            @(posedge Clock);
            waited++;
        end
        if (captured.size() > 0)
        begin
            got = captured.pop_front();
        end
        else if (!timedOut)
        begin
            $display("Timeout at %0t: no pixel arrived within %0d cycles", $time, waitLimit);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic waitGameOver();
        int waited;
        waited = 0;
        while (!gameOver && !timedOut && waited < waitLimit)
        begin
            @(posedge Clock);
            waited++;
        end
        if (!gameOver && !timedOut)
        begin
            $display("Timeout at %0t: gameOver never rose", $time);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    // done, check and game-over follow the last erase pixel within four cycles
    task automatic confirmNoGameOver();
        repeat (4) @(posedge Clock);
        compareFlag("gameOver", gameOver, 1'b0);
    endtask

    task automatic resetDut();
        @(posedge Clock);
        reset <= 1'b1;
        keys <= '0;
        grow <= 1'b0;
        start <= 1'b0;
        repeat (5) @(posedge Clock);
        reset <= 1'b0;
        maxOutstanding = 0;
        // body hangs below the head one block apart
        for (int i = 0; i < snakePkg::maxLength; i++)
        begin
            modelX[i] = snakePkg::startX;
            modelY[i] = snakePkg::startY + i * snakePkg::blockSize;
        end
        modelLength = 1;
    endtask

    task automatic holdKeys(input logic right, input logic down, input logic up,
                            input logic left);
        @(posedge Clock);
        keys <= {right, down, up, left};
    endtask

    task automatic pulseGrow();
        @(posedge Clock);
        grow <= 1'b1;
        @(posedge Clock);
        grow <= 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge Clock);
        start <= 1'b1;
        @(posedge Clock);
        start <= 1'b0;
    endtask

    // head steps one block, the rest follow
    task automatic moveModel(input int dx, input int dy);
        for (int i = snakePkg::maxLength - 1; i > 0; i--)
        begin
            modelX[i] = modelX[i-1];
            modelY[i] = modelY[i-1];
        end
        modelX[0] = modelX[0] + dx;
        modelY[0] = modelY[0] + dy;
    endtask

    // 100 pixels, x fastest
    task automatic expectBlock(input int originX, input int originY,
                               input logic [snakePkg::colorWidth-1:0] color);
        snakePkg::pixelWrite got;
        snakePkg::pixelWrite exp;
        for (int row = 0; row < snakePkg::blockSize; row++)
        begin
            for (int col = 0; col < snakePkg::blockSize; col++)
            begin
                exp.pos.x = snakePkg::xWidth'(originX + col);
                exp.pos.y = snakePkg::yWidth'(originY + row);
                exp.color = color;
                waitPixel(got);
                if (!timedOut)
                begin
                    comparePixel("pixel", got, exp);
                end
            end
        end
    endtask

    // tail first down to the head
    task automatic expectSnake(input logic [snakePkg::colorWidth-1:0] color);
        for (int i = modelLength - 1; i >= 0; i--)
        begin
            expectBlock(modelX[i], modelY[i], color);
        end
    endtask

    task automatic expectFrame();
        expectBlock(snakePkg::appleX, snakePkg::appleY, snakePkg::appleColor);
        expectSnake(snakeColor);
        expectSnake(snakePkg::eraseColor);
    endtask

    task automatic idleTest();
        resetDut();
        repeat (200) @(posedge Clock);
        compareFlag("pixelValid", captured.size() != 0, 1'b0);
        compareFlag("gameOver", gameOver, 1'b0);
    endtask

    task automatic firstFrameTest();
        resetDut();
        snakeColor <= 3'b010;
        pulseStart();
        expectFrame();
        confirmNoGameOver();
    endtask

    task automatic backPressureTest();
        resetDut();
        slowCredits = 1'b1;
        snakeColor <= 3'b011;
        pulseStart();
        expectFrame();
        compareFlag("outstanding above creditDepth", maxOutstanding > snakePkg::creditDepth,
            1'b0);
        slowCredits = 1'b0;
    endtask

    task automatic growTest();
        resetDut();
        snakeColor <= 3'b001;
        holdKeys(1'b1, 1'b0, 1'b0, 1'b0);
        repeat (3) pulseGrow();
        modelLength = 4;
        pulseStart();
        expectFrame();
        moveModel(snakePkg::blockSize, 0);
        expectFrame();
        confirmNoGameOver();
    endtask

    task automatic borderTest();
        resetDut();
        snakeColor <= 3'b110;
        holdKeys(1'b0, 1'b0, 1'b1, 1'b0);
        pulseStart();
        // head climbs from 60 to 10 without a hit
        for (int frame = 0; frame < 6; frame++)
        begin
            expectFrame();
            confirmNoGameOver();
            moveModel(0, -snakePkg::blockSize);
        end
        // head now on the top border
        expectFrame();
        waitGameOver();
        repeat (300) @(posedge Clock);
        compareFlag("pixelValid", captured.size() != 0, 1'b0);
        compareFlag("gameOver", gameOver, 1'b1);
    endtask

    task automatic selfHitTest();
        resetDut();
        snakeColor <= 3'b101;
        holdKeys(1'b0, 1'b0, 1'b1, 1'b0);
        repeat (2) pulseGrow();
        modelLength = 3;
        pulseStart();
        expectFrame();
        moveModel(0, -snakePkg::blockSize);
        // turn back once the first move is done
        expectBlock(snakePkg::appleX, snakePkg::appleY, snakePkg::appleColor);
        holdKeys(1'b0, 1'b1, 1'b0, 1'b0);
        expectSnake(snakeColor);
        expectSnake(snakePkg::eraseColor);
        confirmNoGameOver();
        // head lands on segment 2
        moveModel(0, snakePkg::blockSize);
        expectFrame();
        waitGameOver();
        repeat (300) @(posedge Clock);
        compareFlag("pixelValid", captured.size() != 0, 1'b0);
        compareFlag("gameOver", gameOver, 1'b1);
    endtask

    initial
    begin
        Clock = 1'b0;
        reset = 1'b1;
        keys = '0;
        grow = 1'b0;
        start = 1'b0;
        snakeColor = '0;
        lfsrState = 32'hc7530d06;
        slowCredits = 1'b0;
        cycleCount = 0;
        outstanding = 0;
        maxOutstanding = 0;
        errorCount = 0;
        timeoutCount = 0;
        timedOut = 1'b0;

        idleTest();
        firstFrameTest();
        backPressureTest();
        growTest();
        borderTest();
        selfHitTest();

        $display("Checks finished with %0d mismatches and %0d timeouts",
            errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/snakePkg.sv
src/collisionCheck.sv
src/snakeBody.sv
src/blockRaster.sv
src/gameSequencer.sv
src/snakeGame.sv
dv/snakeGameChecker.sv
dv/snakeGameTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module snakeGameTb -f verilog.f -o snakeGameSim
output=$(./obj_dir/snakeGameSim 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "Done: no errors"
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
